// File: hw/fetch_settings.svh
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// Fetch addresses
//////////////////////////////////////////////////////////////////////

`define RESET_PC        32'hbfc00000
`define EXC_VECTOR      32'hbfc00380   // Common entry for every exception

//////////////////////////////////////////////////////////////////////
// Predictor tables
//////////////////////////////////////////////////////////////////////

`define BTB_INDEX_BITS  4              // 16 entries indexed by pc[5:2]
`define BTB_ENTRIES     (1 << `BTB_INDEX_BITS)
`define BTB_TAG_BITS    (30 - `BTB_INDEX_BITS)

`define PHT_INDEX_BITS  6              // 64 counters indexed by pc[7:2]
`define PHT_ENTRIES     (1 << `PHT_INDEX_BITS)

`define EXC_ADEL        5'd4           // Address error on a fetch

`endif

// File: hw/fetch_pkg.sv
package fetch_pkg;

    //////////////////////////////////////////////////////////////////////
    // Direction counters
    //////////////////////////////////////////////////////////////////////

    // Two-bit saturating counter, the upper half predicts taken
    typedef logic [1:0] sat_counter_t;

    localparam sat_counter_t CTR_STRONG_NT = 2'd0;
    localparam sat_counter_t CTR_WEAK_NT   = 2'd1;   // Value of every counter after reset
    localparam sat_counter_t CTR_WEAK_T    = 2'd2;   // Lowest value that predicts taken
    localparam sat_counter_t CTR_STRONG_T  = 2'd3;

    //////////////////////////////////////////////////////////////////////
    // Exceptions
    //////////////////////////////////////////////////////////////////////

    typedef logic [4:0] exc_code_t;

    //////////////////////////////////////////////////////////////////////
    // Next PC sources
    //////////////////////////////////////////////////////////////////////

    // Listed from highest to lowest priority
    typedef enum logic [2:0] {
        RESET,
        EXCEPTION,
        BRANCH,
        PREDICT,
        SEQUENTIAL
    } pc_source_t;

endpackage

// File: hw/branch_target_buffer.sv
`timescale 1ns/1ps
`include "fetch_settings.svh"

module branch_target_buffer (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] lookup_pc,
    output logic        hit,
    output logic [31:0] target,
    input  logic        br_valid,
    input  logic        br_taken,
    input  logic [31:0] br_pc,
    input  logic [31:0] br_target
);

    localparam int IDX_HI = `BTB_INDEX_BITS + 1;      // Top bit of the index field

    logic [`BTB_ENTRIES-1:0]    entry_valid;
    logic [`BTB_TAG_BITS-1:0]   tag_mem    [`BTB_ENTRIES];
    logic [31:0]                target_mem [`BTB_ENTRIES];

    logic [`BTB_INDEX_BITS-1:0] rd_index;
    logic [`BTB_TAG_BITS-1:0]   rd_tag;
    logic [`BTB_INDEX_BITS-1:0] wr_index;
    logic [`BTB_TAG_BITS-1:0]   wr_tag;
    logic                       wr_en;

    //////////////////////////////////////////////////////////////////////
    // Lookup
    //////////////////////////////////////////////////////////////////////

    assign rd_index = lookup_pc[IDX_HI:2];
    assign rd_tag   = lookup_pc[31:IDX_HI+1];

    assign hit    = entry_valid[rd_index] && (tag_mem[rd_index] == rd_tag);
    assign target = target_mem[rd_index];

    //////////////////////////////////////////////////////////////////////
    // Update
    //////////////////////////////////////////////////////////////////////

    // Only taken branches allocate, a not-taken one leaves its entry alone
    assign wr_en    = br_valid && br_taken;
    assign wr_index = br_pc[IDX_HI:2];
    assign wr_tag   = br_pc[31:IDX_HI+1];

    always_ff @(posedge clk) begin
        if (reset) begin
            entry_valid <= '0;
        end else if (wr_en) begin
            entry_valid[wr_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_index]    <= wr_tag;
            target_mem[wr_index] <= br_target;    // A colliding branch replaces the entry
        end
    end

endmodule

// File: hw/pattern_history_table.sv
`timescale 1ns/1ps
`include "fetch_settings.svh"

module pattern_history_table (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [31:0]             lookup_pc,
    output fetch_pkg::sat_counter_t counter,
    input  logic                    br_valid,
    input  logic                    br_taken,
    input  logic [31:0]             br_pc
);

    localparam int IDX_HI = `PHT_INDEX_BITS + 1;

    fetch_pkg::sat_counter_t    ctr_mem [`PHT_ENTRIES];
    logic [`PHT_INDEX_BITS-1:0] wr_index;
    fetch_pkg::sat_counter_t    cur_ctr;
    fetch_pkg::sat_counter_t    next_ctr;

    assign counter = ctr_mem[lookup_pc[IDX_HI:2]];   // No tag, aliasing branches share a counter

    assign wr_index = br_pc[IDX_HI:2];
    assign cur_ctr  = ctr_mem[wr_index];

    // Saturating step toward the resolved direction
    always_comb begin
        next_ctr = cur_ctr;
        if (br_taken && (cur_ctr != fetch_pkg::CTR_STRONG_T)) begin
            next_ctr = cur_ctr + 2'd1;
        end else if (!br_taken && (cur_ctr != fetch_pkg::CTR_STRONG_NT)) begin
            next_ctr = cur_ctr - 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `PHT_ENTRIES; i++) begin
                ctr_mem[i] <= fetch_pkg::CTR_WEAK_NT;
            end
        end else if (br_valid) begin
            ctr_mem[wr_index] <= next_ctr;
        end
    end

endmodule

// File: hw/branch_predictor.sv
`timescale 1ns/1ps

module branch_predictor (
    input  logic        clk,
    input  logic        reset,
    input  logic        fs_valid,
    input  logic [31:0] fs_pc,
    input  logic        br_valid,
    input  logic        br_taken,
    input  logic [31:0] br_pc,
    input  logic [31:0] br_target,
    output logic        pred_taken,
    output logic [31:0] pred_target
);

    logic                    btb_hit;
    fetch_pkg::sat_counter_t pht_counter;

    //////////////////////////////////////////////////////////////////////
    // Tables, both looked up with the fetch PC
    //////////////////////////////////////////////////////////////////////

    branch_target_buffer u_btb (
        .clk       (clk),
        .reset     (reset),
        .lookup_pc (fs_pc),
        .hit       (btb_hit),
        .target    (pred_target),
        .br_valid  (br_valid),
        .br_taken  (br_taken),
        .br_pc     (br_pc),
        .br_target (br_target)
    );

    pattern_history_table u_pht (
        .clk       (clk),
        .reset     (reset),
        .lookup_pc (fs_pc),
        .counter   (pht_counter),
        .br_valid  (br_valid),
        .br_taken  (br_taken),
        .br_pc     (br_pc)
    );

    // A known target is needed as well as a taken-leaning counter
    assign pred_taken = fs_valid && btb_hit && (pht_counter >= fetch_pkg::CTR_WEAK_T);

endmodule

// File: hw/pre_if_stage.sv
`timescale 1ns/1ps
`include "fetch_settings.svh"

module pre_if_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 fs_allowin,
    input  logic                 flush,
    input  logic                 br_flush,
    input  logic                 br_taken,
    input  logic [31:0]          br_pc,
    input  logic [31:0]          br_target,
    input  logic                 fs_leave,
    input  logic                 pred_taken,
    input  logic [31:0]          pred_target,
    input  logic [31:0]          fs_pc,
    output logic                 ps_to_fs_valid,
    output logic [31:0]          ps_pc,
    output logic                 ps_ex,
    output fetch_pkg::exc_code_t ps_exc_code
);

    fetch_pkg::pc_source_t next_src;
    logic [31:0]           next_pc;
    logic [31:0]           pc_r;        // Start address after a redirect
    logic                  follow_fs;   // The fetch stage holds the previous PC
    logic                  ps_valid;
    logic                  transfer;

    assign transfer = ps_to_fs_valid && fs_allowin;

    //////////////////////////////////////////////////////////////////////
    // Next PC selection
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        if (reset) begin
            next_src = fetch_pkg::RESET;
        end else if (flush) begin
            next_src = fetch_pkg::EXCEPTION;
        end else if (br_flush) begin
            next_src = fetch_pkg::BRANCH;
        end else if (pred_taken) begin
            next_src = fetch_pkg::PREDICT;
        end else begin
            next_src = fetch_pkg::SEQUENTIAL;
        end
    end

    always_comb begin
        case (next_src)
            fetch_pkg::RESET:     next_pc = `RESET_PC;
            fetch_pkg::EXCEPTION: next_pc = `EXC_VECTOR;
            fetch_pkg::BRANCH:    next_pc = br_taken ? br_target : br_pc + 32'd4;
            fetch_pkg::PREDICT:   next_pc = pred_target;
            default:              next_pc = fs_pc + 32'd4;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // PC register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            ps_valid  <= 1'b0;
            follow_fs <= 1'b0;
        end else begin
            ps_valid <= 1'b1;
            if (flush || br_flush) begin
                follow_fs <= 1'b0;
            end else if (transfer) begin
                follow_fs <= 1'b1;
            end else if (fs_leave) begin
                follow_fs <= 1'b0;                // Stage drained with nothing behind it
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush || br_flush || (fs_leave && !transfer)) begin
            pc_r <= next_pc;
        end
    end

    // Once the fetch stage is filled the offered PC tracks its successor
    assign ps_pc          = follow_fs ? next_pc : pc_r;
    assign ps_to_fs_valid = ps_valid;
    assign ps_ex          = (ps_pc[1:0] != 2'b00);
    assign ps_exc_code    = ps_ex ? `EXC_ADEL : 5'd0;

endmodule

// File: hw/if_stage.sv
`timescale 1ns/1ps

module if_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 flush,
    input  logic                 br_flush,
    input  logic                 ps_to_fs_valid,
    input  logic [31:0]          ps_pc,
    input  logic                 ps_ex,
    input  fetch_pkg::exc_code_t ps_exc_code,
    input  logic                 ds_allowin,
    input  logic                 icache_busy,
    input  logic [31:0]          inst_rdata,
    output logic                 fs_allowin,
    output logic                 fs_to_ds_valid,
    output logic                 fs_leave,
    output logic [31:0]          fs_pc,
    output logic [31:0]          fs_inst,
    output logic                 fs_ex,
    output fetch_pkg::exc_code_t fs_exc_code
);

    logic fs_valid;
    logic fs_ready_go;
    logic squash;

    //////////////////////////////////////////////////////////////////////
    // Handshake
    //////////////////////////////////////////////////////////////////////

    assign fs_ready_go    = !icache_busy;             // Memory answers in the cycle it is free
    assign fs_allowin     = !fs_valid || (fs_ready_go && ds_allowin);
    assign fs_to_ds_valid = fs_valid && fs_ready_go;
    assign fs_leave       = fs_to_ds_valid && ds_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            fs_valid <= 1'b0;
        end else if (flush || br_flush) begin
            fs_valid <= 1'b0;                         // Wrong-path slot is dropped
        end else if (fs_allowin) begin
            fs_valid <= ps_to_fs_valid;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stage register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (ps_to_fs_valid && fs_allowin) begin
            fs_pc       <= ps_pc;
            fs_ex       <= ps_ex;
            fs_exc_code <= ps_exc_code;
        end
    end

    // A flushed slot or a faulting fetch reaches decode as a nop
    assign squash  = flush || br_flush || fs_ex;
    assign fs_inst = squash ? 32'd0 : inst_rdata;

endmodule

// File: hw/fetch_frontend.sv
`timescale 1ns/1ps

module fetch_frontend (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 ds_allowin,
    input  logic                 flush,
    input  logic                 br_flush,
    input  logic                 br_valid,
    input  logic                 br_taken,
    input  logic [31:0]          br_pc,
    input  logic [31:0]          br_target,
    output logic [31:0]          inst_addr,
    input  logic [31:0]          inst_rdata,
    input  logic                 icache_busy,
    output logic                 fs_to_ds_valid,
    output logic [31:0]          fs_pc,
    output logic [31:0]          fs_inst,
    output logic                 fs_ex,
    output fetch_pkg::exc_code_t fs_exc_code,
    output logic                 fs_pred_taken,
    output logic [31:0]          fs_pred_target
);

    logic                 ps_to_fs_valid;
    logic [31:0]          ps_pc;
    logic                 ps_ex;
    fetch_pkg::exc_code_t ps_exc_code;
    logic                 fs_allowin;
    logic                 fs_leave;

    pre_if_stage u_pre_if (
        .clk            (clk),
        .reset          (reset),
        .fs_allowin     (fs_allowin),
        .flush          (flush),
        .br_flush       (br_flush),
        .br_taken       (br_taken),
        .br_pc          (br_pc),
        .br_target      (br_target),
        .fs_leave       (fs_leave),
        .pred_taken     (fs_pred_taken),
        .pred_target    (fs_pred_target),
        .fs_pc          (fs_pc),
        .ps_to_fs_valid (ps_to_fs_valid),
        .ps_pc          (ps_pc),
        .ps_ex          (ps_ex),
        .ps_exc_code    (ps_exc_code)
    );

    if_stage u_if (
        .clk            (clk),
        .reset          (reset),
        .flush          (flush),
        .br_flush       (br_flush),
        .ps_to_fs_valid (ps_to_fs_valid),
        .ps_pc          (ps_pc),
        .ps_ex          (ps_ex),
        .ps_exc_code    (ps_exc_code),
        .ds_allowin     (ds_allowin),
        .icache_busy    (icache_busy),
        .inst_rdata     (inst_rdata),
        .fs_allowin     (fs_allowin),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_leave       (fs_leave),
        .fs_pc          (fs_pc),
        .fs_inst        (fs_inst),
        .fs_ex          (fs_ex),
        .fs_exc_code    (fs_exc_code)
    );

    // The prediction only counts once the instruction is actually in hand
    branch_predictor u_bpu (
        .clk         (clk),
        .reset       (reset),
        .fs_valid    (fs_to_ds_valid),
        .fs_pc       (fs_pc),
        .br_valid    (br_valid),
        .br_taken    (br_taken),
        .br_pc       (br_pc),
        .br_target   (br_target),
        .pred_taken  (fs_pred_taken),
        .pred_target (fs_pred_target)
    );

    assign inst_addr = fs_pc;

endmodule

// File: tests/fetch_tb.sv
`timescale 1ns/1ps
`include "fetch_settings.svh"

module fetch_tb;

    localparam int          RESET_CYCLES    = 5;
    localparam int          RANDOM_CYCLES   = 3000;
    localparam int          DIRECTED_CYCLES = 200;
    localparam int          TOTAL_CYCLES    = RESET_CYCLES + RANDOM_CYCLES + DIRECTED_CYCLES;
    localparam logic [31:0] MEM_KEY         = 32'h5a5a0000;
    localparam logic [31:0] LOOP_PC         = `RESET_PC + 32'h48;
    localparam logic [31:0] LOOP_TARGET     = `RESET_PC + 32'h240;
    localparam logic [31:0] ALIAS_PC        = LOOP_PC + 32'h100;   // Shares the index and counter
    localparam logic [31:0] ODD_PC          = `RESET_PC + 32'h302;

    logic                    clk;
    logic                    reset;
    logic                    ds_allowin;
    logic                    flush;
    logic                    br_flush;
    logic                    br_valid;
    logic                    br_taken;
    logic [31:0]             br_pc;
    logic [31:0]             br_target;
    logic [31:0]             inst_addr;
    logic [31:0]             inst_rdata;
    logic                    icache_busy;
    logic                    fs_to_ds_valid;
    logic [31:0]             fs_pc;
    logic [31:0]             fs_inst;
    logic                    fs_ex;
    fetch_pkg::exc_code_t    fs_exc_code;
    logic                    fs_pred_taken;
    logic [31:0]             fs_pred_target;

    // Reference copy of the predictor tables and the fetch stream
    logic                    btb_valid_m  [16];
    logic [25:0]             btb_tag_m    [16];
    logic [31:0]             btb_target_m [16];
    fetch_pkg::sat_counter_t pht_m        [64];
    logic [31:0]             expected_pc;
    logic                    in_reset;
    logic [31:0]             last_accept_pc;
    logic                    last_accept_valid;
    logic                    last_pred;
    logic                    last_ex;
    int                      accept_count;
    logic [15:0]             lfsr_state;
    int                      busy_left;
    string                   test_name;

    fetch_frontend u_dut (
        .clk            (clk),
        .reset          (reset),
        .ds_allowin     (ds_allowin),
        .flush          (flush),
        .br_flush       (br_flush),
        .br_valid       (br_valid),
        .br_taken       (br_taken),
        .br_pc          (br_pc),
        .br_target      (br_target),
        .inst_addr      (inst_addr),
        .inst_rdata     (inst_rdata),
        .icache_busy    (icache_busy),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_pc          (fs_pc),
        .fs_inst        (fs_inst),
        .fs_ex          (fs_ex),
        .fs_exc_code    (fs_exc_code),
        .fs_pred_taken  (fs_pred_taken),
        .fs_pred_target (fs_pred_target)
    );

    always #10 clk = ~clk;

    assign inst_rdata = inst_addr ^ MEM_KEY;    // Stable while the fetch stage holds its PC

    //////////////////////////////////////////////////////////////////////
    // Random numbers and compare tasks
    //////////////////////////////////////////////////////////////////////

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("MISMATCH %s %s: expected %h actual %h", test_name, what, exp, act);
            $display("SOME TESTS FAILED");
            $fatal(1, "Wrong %s", what);
        end
    endtask

    task automatic check_code(input string what, input fetch_pkg::exc_code_t exp,
                              input fetch_pkg::exc_code_t act);
        if (exp !== act) begin
            $display("MISMATCH %s %s: expected %h actual %h", test_name, what, exp, act);
            $display("SOME TESTS FAILED");
            $fatal(1, "Wrong %s", what);
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (exp !== act) begin
            $display("MISMATCH %s %s: expected %b actual %b", test_name, what, exp, act);
            $display("SOME TESTS FAILED");
            $fatal(1, "Wrong %s", what);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    // Taken needs a buffer hit and a counter of 2 or 3
    function automatic logic predicts_taken(input logic [31:0] pc);
        return btb_valid_m[pc[5:2]] && (btb_tag_m[pc[5:2]] == pc[31:6])
               && (pht_m[pc[7:2]] >= 2'd2);
    endfunction

    task automatic reset_model();
        for (int i = 0; i < 16; i++) begin
            btb_valid_m[i] = 1'b0;
        end
        for (int i = 0; i < 64; i++) begin
            pht_m[i] = 2'd1;
        end
        expected_pc = `RESET_PC;
        in_reset    = 1'b1;
    endtask

    always @(posedge clk) begin : model_step
        logic        accepted;
        logic        misaligned;
        logic        exp_pred;
        logic [31:0] exp_inst;
        accepted = fs_to_ds_valid && ds_allowin;
        if (reset) begin
            reset_model();
        end else begin
            if (in_reset) begin
                check_flag("fs_to_ds_valid after reset", 1'b0, fs_to_ds_valid);
                check_flag("fs_pred_taken after reset", 1'b0, fs_pred_taken);
                in_reset = 1'b0;
            end
            if (icache_busy) begin
                check_flag("fs_to_ds_valid while busy", 1'b0, fs_to_ds_valid);
            end
            misaligned = (expected_pc[1:0] != 2'b00);
            exp_pred   = predicts_taken(expected_pc);
            if (accepted) begin
                exp_inst = (flush || br_flush || misaligned) ? 32'd0 : expected_pc ^ MEM_KEY;
                check_word("fs_pc", expected_pc, fs_pc);
                check_word("inst_addr", expected_pc, inst_addr);
                check_word("fs_inst", exp_inst, fs_inst);
                check_flag("fs_ex", misaligned, fs_ex);
                check_code("fs_exc_code", misaligned ? `EXC_ADEL : 5'd0, fs_exc_code);
                check_flag("fs_pred_taken", exp_pred, fs_pred_taken);
                if (exp_pred) begin
                    check_word("fs_pred_target", btb_target_m[expected_pc[5:2]], fs_pred_target);
                end
                accept_count <= accept_count + 1;
            end
            last_accept_valid <= accepted;
            last_accept_pc    <= expected_pc;
            last_pred         <= fs_pred_taken;
            last_ex           <= fs_ex;
            if (flush) begin
                expected_pc = `EXC_VECTOR;
            end else if (br_flush) begin
                expected_pc = br_taken ? br_target : br_pc + 32'd4;
            end else if (accepted) begin
                expected_pc = exp_pred ? btb_target_m[expected_pc[5:2]] : expected_pc + 32'd4;
            end
            if (br_valid && br_taken) begin
                btb_valid_m[br_pc[5:2]]  = 1'b1;
                btb_tag_m[br_pc[5:2]]    = br_pc[31:6];
                btb_target_m[br_pc[5:2]] = br_target;
                if (pht_m[br_pc[7:2]] != 2'd3) pht_m[br_pc[7:2]] = pht_m[br_pc[7:2]] + 2'd1;
            end else if (br_valid && pht_m[br_pc[7:2]] != 2'd0) begin
                pht_m[br_pc[7:2]] = pht_m[br_pc[7:2]] - 2'd1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic drive_cycle(input logic allow, input logic busy, input logic valid,
                               input logic taken, input logic bflush, input logic xflush,
                               input logic [31:0] pc, input logic [31:0] target);
        @(posedge clk);
        ds_allowin  <= allow;
        icache_busy <= busy;
        br_valid    <= valid;
        br_taken    <= taken;
        br_flush    <= bflush;
        flush       <= xflush;
        br_pc       <= pc;
        br_target   <= target;
    endtask

    task automatic idle_cycle();
        drive_cycle(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 32'd0, 32'd0);
    endtask

    task automatic random_cycle();
        logic        valid;
        logic [31:0] target;
        if (busy_left == 0 && rand_bits(3) == 0) busy_left = 1 + rand_bits(2);
        valid  = (rand_bits(3) == 0);
        target = `RESET_PC + (rand_bits(6) << 2);
        if (rand_bits(4) == 0) target = target | rand_bits(2);    // Occasional odd target
        drive_cycle(rand_bits(2) != 0, busy_left > 0, valid, rand_bits(1) != 0,
                    valid && rand_bits(2) == 0, rand_bits(6) == 0,
                    `RESET_PC + (rand_bits(6) << 2), target);
        if (busy_left > 0) busy_left = busy_left - 1;
    endtask

    task automatic wait_accept(input logic [31:0] pc);
        while (!(last_accept_valid && last_accept_pc == pc)) begin
            idle_cycle();
        end
    endtask

    task automatic resolve_branch(input logic [31:0] pc, input logic [31:0] target,
                                  input logic taken);
        drive_cycle(1'b1, 1'b0, 1'b1, taken, 1'b0, 1'b0, pc, target);
    endtask

    // The slots just behind a redirect are old path, so skip past them first
    task automatic redirect(input logic xflush, input logic bflush, input logic taken,
                            input logic [31:0] pc, input logic [31:0] target,
                            input logic [31:0] expect_pc);
        drive_cycle(1'b1, 1'b0, 1'b0, taken, bflush, xflush, pc, target);
        repeat (3) idle_cycle();
        wait_accept(expect_pc);
    endtask

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        ds_allowin   = 1'b0;
        flush        = 1'b0;
        br_flush     = 1'b0;
        br_valid     = 1'b0;
        br_taken     = 1'b0;
        br_pc        = 32'd0;
        br_target    = 32'd0;
        icache_busy  = 1'b0;
        lfsr_state   = 16'd38712;
        busy_left    = 0;
        accept_count = 0;
        test_name    = "random stream";
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        repeat (RANDOM_CYCLES) random_cycle();

        test_name = "exception flush";
        redirect(1'b1, 1'b0, 1'b0, 32'd0, 32'd0, `EXC_VECTOR);
        test_name = "flush over branch";
        redirect(1'b1, 1'b1, 1'b1, 32'd0, `RESET_PC + 32'h500, `EXC_VECTOR);
        test_name = "branch not taken";
        redirect(1'b0, 1'b1, 1'b0, `RESET_PC + 32'h120, 32'd0, `RESET_PC + 32'h124);
        test_name = "misaligned fetch";
        redirect(1'b0, 1'b1, 1'b1, 32'd0, ODD_PC, ODD_PC);
        check_flag("fs_ex at odd PC", 1'b1, last_ex);

        test_name = "prediction learning";
        repeat (2) resolve_branch(LOOP_PC, LOOP_TARGET, 1'b1);
        redirect(1'b0, 1'b1, 1'b1, 32'd0, LOOP_PC, LOOP_PC);
        check_flag("trained branch predicted", 1'b1, last_pred);
        wait_accept(LOOP_TARGET);
        test_name = "prediction unlearning";
        repeat (2) resolve_branch(LOOP_PC, LOOP_TARGET, 1'b0);
        redirect(1'b0, 1'b1, 1'b1, 32'd0, LOOP_PC, LOOP_PC);
        check_flag("untrained branch predicted", 1'b0, last_pred);
        test_name = "buffer tag collision";
        repeat (2) resolve_branch(LOOP_PC, LOOP_TARGET, 1'b1);
        redirect(1'b0, 1'b1, 1'b1, 32'd0, ALIAS_PC, ALIAS_PC);
        check_flag("aliased PC predicted", 1'b0, last_pred);
        idle_cycle();

        if (accept_count < 500) begin
            $display("Fetch stream stalled, only %0d instructions were accepted", accept_count);
            $display("SOME TESTS FAILED");
            $fatal(1, "Too few accepted instructions");
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

    initial begin
        #(TOTAL_CYCLES * 20 * 4);
        $display("Run timed out before all tests finished");
        $display("SOME TESTS FAILED");
        $fatal(1, "Timeout");
    end

endmodule

// File: verilog.f
+incdir+hw
hw/fetch_pkg.sv
hw/branch_target_buffer.sv
hw/pattern_history_table.sv
hw/branch_predictor.sv
hw/pre_if_stage.sv
hw/if_stage.sv
hw/fetch_frontend.sv
tests/fetch_tb.sv

// File: Bender.yml
package:
  name: fetch_frontend

sources:
  - include_dirs:
      - hw
    files:
      - hw/fetch_pkg.sv
      - hw/branch_target_buffer.sv
      - hw/pattern_history_table.sv
      - hw/branch_predictor.sv
      - hw/pre_if_stage.sv
      - hw/if_stage.sv
      - hw/fetch_frontend.sv

  - target: test
    include_dirs:
      - hw
    files:
      - tests/fetch_tb.sv
